// File: tb/golden_accesses.txt
// columns, one hex digit each except addr: b2b op addr(tag,set) hit way alloc
// b2b 1 = driven in the cycle right after the previous request, op 1 = invalidate
// cold misses in set 3 fill ways 0..3
00103001
00203011
00303021
00403031
// hits in way order 0 1 2 3 then 0 again
00103100
00203110
00303120
00403130
00103100
// tree victim is way 2, then evicted tag 30 misses and lands in way 1
00503021
00303011
// invalidate tag 10, its lookup refills the freed way 0
01103100
00103001
00103100
// back-to-back over different sets, same tag in set 4 is independent
00a15001
10a26001
10a37001
10104001
10a15100
// back-to-back in set 9
00119001
10229011
10119100
10339021
10229110
11229110
10229011
10449031
10559001
10119021
// set 3 still holds 30, 50, 40
00303110
00503120
00403130

// File: build.f
common/cache_pkg.sv
rtl/set_regfile.sv
replacement/replacement_policy.sv
tag_store/tag_store.sv
rtl/cache_directory.sv
tb/cache_directory_tb.sv

// File: tb/cache_directory_tb.sv
`timescale 1ns/1ps

// testbench for the tree plru build of cache_directory
// requests and expected responses come from tb/golden_accesses.txt
module cache_directory_tb;

    localparam int                     N_WAYS     = cache_pkg::DEFAULT_N_WAYS;
    localparam int                     SET_W      = cache_pkg::DEFAULT_SET_W;
    localparam int                     TAG_W      = cache_pkg::DEFAULT_TAG_W;
    localparam cache_pkg::rep_policy_e REP_POLICY = cache_pkg::rep_plru_tree;
    localparam int                     WAY_W      = $clog2(N_WAYS);
    localparam int                     ADDR_W     = TAG_W + SET_W;

    localparam int CLK_PERIOD = 100;        // ns
    localparam int RST_CYCLES = 8;
    localparam int MAX_LINES  = 64;         // golden file capacity
    localparam int LATENCY    = 2;          // edges from request to response

    logic                 clk;
    logic                 rst_n;
    logic                 req_valid;
    cache_pkg::cache_op_e req_op;
    logic [ADDR_W-1:0]    req_addr;
    logic                 resp_valid;
    logic                 resp_hit;
    logic [WAY_W-1:0]     resp_way;
    logic                 resp_alloc;

    // one word per request with b2b op addr hit way alloc as hex digits
    logic [31:0] golden [MAX_LINES];

    int n_lines     = 0;
    int cycle       = 0;                    // rising edges since time 0
    int cycle_limit = 0;                    // 0 until the golden file is read
    int n_errors    = 0;
    int n_pass      = 0;
    int n_fail      = 0;
    bit test_ok;

    int exp_line_q  [$];                    // golden index of each outstanding request
    int exp_cycle_q [$];                    // cycle count when it was driven

    cache_directory #(
        .N_WAYS     (N_WAYS),
        .SET_W      (SET_W),
        .TAG_W      (TAG_W),
        .REP_POLICY (REP_POLICY)
    ) dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req_op     (req_op),
        .req_addr   (req_addr),
        .resp_valid (resp_valid),
        .resp_hit   (resp_hit),
        .resp_way   (resp_way),
        .resp_alloc (resp_alloc)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // cycle count and run limit
    always @(posedge clk) begin
        cycle++;
        if (cycle_limit > 0 && cycle >= cycle_limit) begin
            $display("timeout: %0d cycles passed with %0d responses still outstanding",
                     cycle, exp_line_q.size());
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    task automatic check_hit(input logic got, input logic exp, input int line);
        if (got !== exp) begin
            $display("** Error at %0t ns: resp_hit = %0b, expected %0b (request %0d)",
                     $time, got, exp, line);
            n_errors++;
            test_ok = 1'b0;
        end
    endtask

    task automatic check_way(input logic [WAY_W-1:0] got, input logic [WAY_W-1:0] exp,
                             input int line);
        if (got !== exp) begin
            $display("** Error at %0t ns: resp_way = %0d, expected %0d (request %0d)",
                     $time, got, exp, line);
            n_errors++;
            test_ok = 1'b0;
        end
    endtask

    task automatic check_alloc(input logic got, input logic exp, input int line);
        if (got !== exp) begin
            $display("** Error at %0t ns: resp_alloc = %0b, expected %0b (request %0d)",
                     $time, got, exp, line);
            n_errors++;
            test_ok = 1'b0;
        end
    endtask

    // response monitor samples on the falling edge where outputs are stable
    always @(negedge clk) begin
        int          line;
        int          issued;
        logic [31:0] g;
        if (rst_n && resp_valid) begin
            if (exp_line_q.size() == 0) begin
                $display("response at %0t ns with no request outstanding", $time);
                n_errors++;
            end else begin
                line    = exp_line_q.pop_front();
                issued  = exp_cycle_q.pop_front();
                g       = golden[line];
                test_ok = 1'b1;
                check_hit(resp_hit, g[8], line);
                check_way(resp_way, g[4 +: WAY_W], line);
                check_alloc(resp_alloc, g[0], line);
                if (cycle - issued != LATENCY) begin   // order and latency in one test
                    $display("request %0d answered %0d cycles after it was driven, not %0d",
                             line, cycle - issued, LATENCY);
                    n_errors++;
                    test_ok = 1'b0;
                end
                if (test_ok) n_pass++;
                else n_fail++;
                $display("request %2d: %s %h -> hit %0b way %0d alloc %0b  %s", line,
                         g[24] ? "inval " : "lookup", g[23:12], resp_hit, resp_way,
                         resp_alloc, test_ok ? "ok" : "mismatch");
            end
        end
    end

    initial begin
        int gap;
        void'($urandom(32'h2729_90d7));    // one seed for the whole run
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req_op    = cache_pkg::op_lookup;
        req_addr  = '0;

        for (int i = 0; i < MAX_LINES; i++) begin
            golden[i] = '1;                 // all ones marks an unused entry
        end
        $readmemh("tb/golden_accesses.txt", golden);
        while (n_lines < MAX_LINES && golden[n_lines] !== '1) n_lines++;
        if (n_lines == 0) begin
            $display("no requests found in tb/golden_accesses.txt");
            n_errors++;
        end
        cycle_limit = n_lines * 8 + 100;

        repeat (RST_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        for (int line = 0; line < n_lines; line++) begin
            if (!golden[line][28]) begin    // idle gap unless marked back-to-back
                req_valid = 1'b0;
                gap = $urandom_range(3, 0);
                repeat (gap) @(negedge clk);
            end
            req_valid = 1'b1;
            req_op    = cache_pkg::cache_op_e'(golden[line][24]);
            req_addr  = golden[line][12 +: ADDR_W];
            exp_line_q.push_back(line);
            exp_cycle_q.push_back(cycle);
            @(negedge clk);
        end
        req_valid = 1'b0;

        // room for the last response plus a few cycles for strays
        repeat (LATENCY + 4) @(negedge clk);

        if (n_pass + n_fail != n_lines) begin
            $display("%0d of %0d requests got a response", n_pass + n_fail, n_lines);
            n_errors++;
        end
        $display("%0d requests, %0d passed, %0d failed, %0d errors",
                 n_lines, n_pass, n_fail, n_errors);
        if (n_errors == 0 && n_fail == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: rtl/cache_directory.sv
`timescale 1ns/1ps

// cache tag directory top with request, stage 1 and response register
module cache_directory #(
    parameter int                     N_WAYS     = cache_pkg::DEFAULT_N_WAYS,
    parameter int                     SET_W      = cache_pkg::DEFAULT_SET_W,
    parameter int                     TAG_W      = cache_pkg::DEFAULT_TAG_W,
    parameter cache_pkg::rep_policy_e REP_POLICY = cache_pkg::rep_plru_tree,
    localparam int                    WAY_W      = $clog2(N_WAYS),
    localparam int                    ADDR_W     = TAG_W + SET_W
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 req_valid,     // single-cycle strobe, always taken
    input  cache_pkg::cache_op_e req_op,
    input  logic [ADDR_W-1:0]    req_addr,
    output logic                 resp_valid,    // two edges after req_valid
    output logic                 resp_hit,
    output logic [WAY_W-1:0]     resp_way,
    output logic                 resp_alloc
);

    // stage 1 request
    logic                 s1_valid;
    cache_pkg::cache_op_e s1_op;
    logic [ADDR_W-1:0]    s1_addr;
    logic [SET_W-1:0]     s1_set;
    logic [TAG_W-1:0]     s1_tag;

    logic [N_WAYS-1:0] way_hit;
    logic [N_WAYS-1:0] free_way;
    logic [N_WAYS-1:0] victim_way;
    logic [WAY_W-1:0]  victim_bin;

    logic              s1_lookup;
    logic              s1_hit;
    logic              alloc_en;
    logic              inval_en;
    logic [N_WAYS-1:0] alloc_way_onehot;
    logic [N_WAYS-1:0] access_way;
    logic [N_WAYS-1:0] sel_onehot;      // hit way, else free way
    logic [WAY_W-1:0]  sel_bin;
    logic [WAY_W-1:0]  way_bin;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            s1_op    <= cache_pkg::op_lookup;
            s1_addr  <= '0;             // set 0 is read until the first request
        end else begin
            s1_valid <= req_valid;
            if (req_valid) begin
                s1_op   <= req_op;
                s1_addr <= req_addr;
            end
        end
    end

    assign s1_set = s1_addr[SET_W-1:0];         // index in the low bits
    assign s1_tag = s1_addr[ADDR_W-1 -: TAG_W];

    assign s1_lookup = s1_valid && (s1_op == cache_pkg::op_lookup);
    assign s1_hit    = |way_hit;

    // an empty way beats the policy victim
    assign alloc_way_onehot = (|free_way) ? free_way : victim_way;
    assign alloc_en         = s1_lookup && !s1_hit;
    assign inval_en         = s1_valid && (s1_op == cache_pkg::op_invalidate);
    assign access_way       = s1_hit ? way_hit : alloc_way_onehot;

    // victim index already comes binary from the policy block
    assign sel_onehot = s1_hit ? way_hit : free_way;
    always_comb begin
        sel_bin = '0;
        for (int i = 0; i < N_WAYS; i++) begin
            if (sel_onehot[i]) sel_bin |= WAY_W'(i);
        end
    end
    assign way_bin = (|sel_onehot) ? sel_bin : victim_bin;

    tag_store #(
        .N_WAYS    (N_WAYS),
        .SET_W     (SET_W),
        .TAG_W     (TAG_W)
    ) u_tag_store (
        .clk       (clk),
        .rst_n     (rst_n),
        .set       (s1_set),
        .tag       (s1_tag),
        .alloc_en  (alloc_en),
        .alloc_way (alloc_way_onehot),
        .inval_en  (inval_en),
        .way_hit   (way_hit),
        .free_way  (free_way)
    );

    replacement_policy #(
        .N_WAYS     (N_WAYS),
        .SET_W      (SET_W),
        .REP_POLICY (REP_POLICY)
    ) u_replacement (
        .clk        (clk),
        .rst_n      (rst_n),
        .access_en  (s1_lookup),        // invalidates leave the policy alone
        .access_way (access_way),
        .line_addr  (s1_set),
        .victim_way (victim_way),
        .victim_bin (victim_bin)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= s1_valid;
        end
    end

    // response payload loads with the same edge as the directory writes
    always_ff @(posedge clk) begin
        if (s1_valid) begin
            resp_hit   <= s1_hit;
            resp_way   <= way_bin;
            resp_alloc <= alloc_en;
        end
    end

    // every response traces back to a strobe exactly two edges earlier
    a_resp_from_req : assert property (
        @(posedge clk) disable iff (!rst_n) resp_valid |-> $past(req_valid, 2)
    ) else $error("cache_directory: resp_valid without a request two cycles before");

endmodule

// File: tag_store/tag_store.sv
`timescale 1ns/1ps

// per-way tags and valid bits, tag compare, free way search
module tag_store #(
    parameter int N_WAYS = cache_pkg::DEFAULT_N_WAYS,
    parameter int SET_W  = cache_pkg::DEFAULT_SET_W,
    parameter int TAG_W  = cache_pkg::DEFAULT_TAG_W
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [SET_W-1:0]  set,
    input  logic [TAG_W-1:0]  tag,
    input  logic              alloc_en,     // write tag, set valid
    input  logic [N_WAYS-1:0] alloc_way,    // one-hot target of the allocation
    input  logic              inval_en,     // clear valid of the hit way
    output logic [N_WAYS-1:0] way_hit,      // one-hot or zero
    output logic [N_WAYS-1:0] free_way      // lowest invalid way, zero when full
);

    logic [TAG_W-1:0]  tag_rd [N_WAYS];     // stored tag of each way in this set
    logic [N_WAYS-1:0] valid_rd;            // valid bits of this set
    logic [N_WAYS-1:0] valid_wr;
    logic              valid_we;

    genvar w;
    generate
        for (w = 0; w < N_WAYS; w++) begin : g_way
            // tag memory of one way, written only when it gets the new line
            set_regfile #(
                .ADDR_W (SET_W),
                .DATA_W (TAG_W)
            ) u_tag_mem (
                .clk    (clk),
                .rst_n  (rst_n),
                .we     (alloc_en & alloc_way[w]),
                .addr   (set),
                .w_data (tag),
                .r_data (tag_rd[w])
            );

            assign way_hit[w] = valid_rd[w] && (tag_rd[w] == tag);
        end
    endgenerate

    // lowest zero bit of the valid word
    assign free_way = ~valid_rd & (valid_rd + N_WAYS'(1));

    // allocate sets a bit, invalidate drops the hit bit
    // (no hit -> word written back unchanged)
    assign valid_we = alloc_en | inval_en;
    assign valid_wr = alloc_en ? (valid_rd | alloc_way) : (valid_rd & ~way_hit);

    set_regfile #(
        .ADDR_W (SET_W),
        .DATA_W (N_WAYS)
    ) u_valid_mem (
        .clk    (clk),
        .rst_n  (rst_n),
        .we     (valid_we),
        .addr   (set),
        .w_data (valid_wr),
        .r_data (valid_rd)
    );

    // allocation only follows a miss, so a tag lives in at most one way
    a_hit_onehot0 : assert property (
        @(posedge clk) disable iff (!rst_n) $onehot0(way_hit)
    ) else $error("tag_store: tag present in more than one way (%b)", way_hit);

endmodule

// File: replacement/replacement_policy.sv
`timescale 1ns/1ps

// per-set replacement state and victim selection
// lru, mru pseudo lru and tree pseudo lru, picked by REP_POLICY
module replacement_policy #(
    parameter int                     N_WAYS     = cache_pkg::DEFAULT_N_WAYS,
    parameter int                     SET_W      = cache_pkg::DEFAULT_SET_W,
    parameter cache_pkg::rep_policy_e REP_POLICY = cache_pkg::rep_plru_tree,
    localparam int                    WAY_W      = $clog2(N_WAYS)
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              access_en,    // one-cycle write of the set state
    input  logic [N_WAYS-1:0] access_way,   // one-hot, way just used
    input  logic [SET_W-1:0]  line_addr,
    output logic [N_WAYS-1:0] victim_way,   // one-hot
    output logic [WAY_W-1:0]  victim_bin
);

    // state word width per set depends on the algorithm
    localparam int STATE_W = (REP_POLICY == cache_pkg::rep_lru)      ? N_WAYS * WAY_W :
                             (REP_POLICY == cache_pkg::rep_plru_mru) ? N_WAYS
                                                                     : N_WAYS - 1;

    logic [STATE_W-1:0] state_rd;   // current state of the addressed set
    logic [STATE_W-1:0] state_wr;   // state after this access

    generate
        if (REP_POLICY == cache_pkg::rep_lru) begin : g_lru
            // rank per way, N_WAYS-1 is most recent, 0 is the victim
            logic [WAY_W-1:0] rank_q [N_WAYS];
            logic [WAY_W-1:0] acc_rank;     // old rank of the accessed way

            always_comb begin
                acc_rank = '0;
                // an all-zero word means the set was cleared, use identity ranking
                for (int i = 0; i < N_WAYS; i++) begin
                    rank_q[i] = (|state_rd) ? state_rd[i*WAY_W +: WAY_W] : WAY_W'(i);
                end
                for (int i = 0; i < N_WAYS; i++) begin
                    if (access_way[i]) acc_rank |= rank_q[i];
                end
                for (int i = 0; i < N_WAYS; i++) begin
                    if (access_way[i]) begin
                        state_wr[i*WAY_W +: WAY_W] = WAY_W'(N_WAYS - 1);   // becomes mru
                    end else if (rank_q[i] > acc_rank) begin
                        state_wr[i*WAY_W +: WAY_W] = rank_q[i] - WAY_W'(1); // steps down
                    end else begin
                        state_wr[i*WAY_W +: WAY_W] = rank_q[i];
                    end
                    victim_way[i] = (rank_q[i] == '0);
                end
            end
        end else if (REP_POLICY == cache_pkg::rep_plru_mru) begin : g_plru_mru
            logic [N_WAYS-1:0] mru_set;     // bits with this access merged in

            assign mru_set = state_rd | access_way;
            // all ways used -> restart with only the newest bit
            assign state_wr = (&mru_set) ? access_way : mru_set;
            // lowest clear bit, never empty since a full word is never stored
            assign victim_way = ~state_rd & (state_rd + N_WAYS'(1));
        end else begin : g_plru_tree
            // heap order, node 1 is the root, node n has children 2n and 2n+1
            // a node bit of 0 points left, 1 points right
            logic [N_WAYS-1:1] tree_q;
            logic [N_WAYS-1:1] tree_d;
            logic [WAY_W-1:0]  acc_bin;     // accessed way as index
            logic [WAY_W:0]    path;        // node on the accessed way's path
            logic [WAY_W:0]    node;        // walk pointer for the victim

            assign tree_q   = state_rd;
            assign state_wr = tree_d;

            always_comb begin
                acc_bin = '0;
                for (int i = 0; i < N_WAYS; i++) begin
                    if (access_way[i]) acc_bin |= WAY_W'(i);
                end

                // leaf id is N_WAYS + way, shifting it up gives each ancestor
                tree_d = tree_q;
                path   = '0;
                for (int lvl = 0; lvl < WAY_W; lvl++) begin
                    path = {1'b1, acc_bin} >> (WAY_W - lvl);
                    tree_d[path] = ~acc_bin[WAY_W-1-lvl];   // point away from this way
                end

                // follow the node bits from the root down to a leaf
                node = (WAY_W + 1)'(1);
                for (int lvl = 0; lvl < WAY_W; lvl++) begin
                    node = {node[WAY_W-1:0], tree_q[node]};
                end
                victim_way = N_WAYS'(1) << node[WAY_W-1:0];   // leaf id minus N_WAYS
            end
        end
    endgenerate

    // victim index, shared by all three algorithms
    always_comb begin
        victim_bin = '0;
        for (int i = 0; i < N_WAYS; i++) begin
            if (victim_way[i]) victim_bin |= WAY_W'(i);
        end
    end

    set_regfile #(
        .ADDR_W (SET_W),
        .DATA_W (STATE_W)
    ) u_state_mem (
        .clk    (clk),
        .rst_n  (rst_n),
        .we     (access_en),
        .addr   (line_addr),
        .w_data (state_wr),
        .r_data (state_rd)
    );

    // any stored or cleared state must name exactly one way
    a_victim_onehot : assert property (
        @(posedge clk) disable iff (!rst_n) $onehot(victim_way)
    ) else $error("replacement_policy: victim_way not one-hot (%b)", victim_way);

endmodule

// File: rtl/set_regfile.sv
`timescale 1ns/1ps

// one word per set, async clear, read is combinational
module set_regfile #(
    parameter int ADDR_W = cache_pkg::DEFAULT_SET_W,
    parameter int DATA_W = cache_pkg::DEFAULT_TAG_W
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              we,
    input  logic [ADDR_W-1:0] addr,
    input  logic [DATA_W-1:0] w_data,
    output logic [DATA_W-1:0] r_data
);

    localparam int DEPTH = 1 << ADDR_W;

    logic [DATA_W-1:0] mem [DEPTH];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // every set comes up empty / cleared
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            mem[addr] <= w_data;    // lands at the edge, visible next cycle
        end
    end

    assign r_data = mem[addr];      // same-cycle read of the addressed set

endmodule

// File: common/cache_pkg.sv
package cache_pkg;

    // replacement algorithm select, fixed per build
    typedef enum logic [1:0] {
        rep_lru       = 2'd0,   // true lru, rank counter per way
        rep_plru_mru  = 2'd1,   // one mru bit per way
        rep_plru_tree = 2'd2    // binary tree of node bits
    } rep_policy_e;

    // request opcode carried with req_valid
    typedef enum logic {
        op_lookup     = 1'b0,   // compare, allocate on miss
        op_invalidate = 1'b1    // drop the matching line
    } cache_op_e;

    // default geometry, overridden from the top level
    parameter int DEFAULT_N_WAYS = 4;    // power of two, 2 or more
    parameter int DEFAULT_SET_W  = 4;    // 16 sets
    parameter int DEFAULT_TAG_W  = 8;

endpackage
